// File: design/uart_pkg.sv
////////////////////////////////////////////////////////////
// Shared definitions for the memory-mapped 8N1 UART
// Timing constants, register offsets, Wishbone bus structs,
// the status bits and the two views of a bus write word
////////////////////////////////////////////////////////////
package uart_pkg;

	// Clock cycles per 16x oversample tick
	localparam int TICK_CLKS = 4;
	localparam int OVERSAMPLE = 16; // Ticks per bit on the line
	localparam int BIT_CLKS = TICK_CLKS * OVERSAMPLE; // Clock cycles per serial bit

	// Counter widths and terminal counts derived from the rates above
	localparam int TICK_CNT_W = $clog2(TICK_CLKS);
	localparam int OS_CNT_W = $clog2(OVERSAMPLE);
	localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(TICK_CLKS - 1);
	localparam logic [OS_CNT_W-1:0] OS_LAST = OS_CNT_W'(OVERSAMPLE - 1); // Last tick of a bit
	// Tick at which the middle of the start bit is reached after detection
	localparam logic [OS_CNT_W-1:0] OS_HALF = OS_CNT_W'(OVERSAMPLE / 2 - 1);

	// Byte offsets of the four word registers
	localparam logic [31:0] ADR_CMD = 32'h0000_0000; // Command register always reads zero
	localparam logic [31:0] ADR_STATUS = 32'h0000_0004;
	localparam logic [31:0] ADR_RXBUF = 32'h0000_0008;
	localparam logic [31:0] ADR_TXBUF = 32'h0000_000c;

	// Wishbone classic request from the master
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat; // Write data
		logic we;
		logic stb;
		logic cyc;
	} wb_req_t;

	// Wishbone classic response from the register block
	typedef struct packed {
		logic [31:0] dat; // Read data is valid while ack is high
		logic ack;
	} wb_rsp_t;

	// Low three bits of the status word with cts at bit 0
	typedef struct packed {
		logic ovr; // A byte arrived while rdy was still set
		logic rdy; // Receive buffer holds an unread byte
		logic cts; // Transmitter is idle
	} uart_status_t;

	// Command view of a write word
	typedef struct packed {
		logic [29:0] rsvd;
		logic clear; // Clears rdy and ovr
		logic send;  // Starts a frame from the send buffer
	} cmd_word_t;

	// Data view of a write word
	typedef struct packed {
		logic [23:0] rsvd;
		logic [7:0] data;
	} data_word_t;

	// The same write data means different things at ADR_CMD and ADR_TXBUF
	typedef union packed {
		cmd_word_t cmd;
		data_word_t data;
	} wr_word_u;

endpackage

// File: design/uart_baud_gen.sv
////////////////////////////////////////////////////////////
// Fixed-rate baud generator for the UART
// Pulses tick16 for one clock every TICK_CLKS clocks, which
// paces both the transmitter and the oversampling receiver
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_baud_gen (
	input logic clk,
	input logic rst,
	output logic tick16
);

	logic [uart_pkg::TICK_CNT_W-1:0] cnt; // Clock cycles since the last tick

	// Free-running divider with a registered tick output
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0; // Divider restarts from zero
			tick16 <= 1'b0;
		end else if (cnt == uart_pkg::TICK_LAST) begin
			cnt <= '0;
			tick16 <= 1'b1; // One cycle wide on every wrap
		end else begin
			cnt <= cnt + 1'b1;
			tick16 <= 1'b0;
		end
	end

endmodule

// File: design/uart_receiver.sv
////////////////////////////////////////////////////////////
// Oversampling 8N1 receiver
// Finds the start bit, samples each bit in its middle and
// strobes rx_valid for one clock when the stop bit is high
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_receiver (
	input logic clk,
	input logic rst,
	input logic tick16,
	input logic rxd,
	output logic [7:0] rx_byte,
	output logic rx_valid
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	logic rxd_meta; // First synchronizer stage
	logic rxd_sync; // Safe to use in the FSM
	logic [uart_pkg::OS_CNT_W-1:0] tick_cnt; // Ticks since the last sample point
	logic [2:0] bit_idx; // Data bit being received

	// The line is asynchronous to clk, so bring it in through two flops
	always_ff @(posedge clk) begin
		if (rst) begin
			rxd_meta <= 1'b1; // Idle line level
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RX_IDLE;
			tick_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0; // Strobe, only one cycle long
			if (tick16) begin
				case (state)
					RX_IDLE: begin
						if (!rxd_sync) begin // Falling edge seen on a tick
							state <= RX_START;
							tick_cnt <= '0;
						end
					end
					RX_START: begin
						if (tick_cnt == uart_pkg::OS_HALF) begin
							// Middle of the start bit, a high line here was only a glitch
							state <= rxd_sync ? RX_IDLE : RX_DATA;
							tick_cnt <= '0;
							bit_idx <= '0;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_DATA: begin
						if (tick_cnt == uart_pkg::OS_LAST) begin
							tick_cnt <= '0;
							bit_idx <= bit_idx + 1'b1;
							if (bit_idx == 3'd7)
								state <= RX_STOP; // All eight bits are in
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_STOP: begin
						if (tick_cnt == uart_pkg::OS_LAST) begin
							// Middle of the stop bit, a low level is a framing error and the byte is dropped.
							// If the line is still low the next start is rejected as a glitch
							state <= RX_IDLE;
							tick_cnt <= '0;
							rx_valid <= rxd_sync;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// Shift register for the data byte, LSB arrives first and ends up at bit 0
	always_ff @(posedge clk) begin
		if (tick16 && state == RX_DATA && tick_cnt == uart_pkg::OS_LAST)
			rx_byte <= {rxd_sync, rx_byte[7:1]};
	end

	a_rx_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		rx_valid |=> !rx_valid)
		else $error("rx_valid held longer than one cycle");

endmodule

// File: design/uart_transmitter.sv
////////////////////////////////////////////////////////////
// 8N1 serializer for the UART
// Accepts tx_start while cts is high, then sends start bit,
// eight data bits LSB first and stop bit from a register
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_transmitter (
	input logic clk,
	input logic rst,
	input logic tick16,
	input logic tx_start,
	input logic [7:0] tx_byte,
	output logic cts,
	output logic txd
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_WAIT, // Accepted, waiting for the next tick to start
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t state;
	logic [7:0] tx_data; // Byte latched at accept time
	logic [uart_pkg::OS_CNT_W-1:0] tick_cnt; // Ticks spent in the current bit
	logic [2:0] bit_idx;

	assign cts = (state == TX_IDLE); // Clear to send only when nothing is in flight

	// Latch the byte once per frame, later starts are ignored while busy
	always_ff @(posedge clk) begin
		if (tx_start && cts)
			tx_data <= tx_byte;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			txd <= 1'b1; // Line idles high
			tick_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (tx_start)
						state <= TX_WAIT;
				end
				TX_WAIT: begin
					if (tick16) begin // Align the frame with the tick grid
						state <= TX_START;
						txd <= 1'b0;
						tick_cnt <= '0;
					end
				end
				TX_START: begin
					if (tick16) begin
						if (tick_cnt == uart_pkg::OS_LAST) begin
							state <= TX_DATA;
							txd <= tx_data[0];
							bit_idx <= '0;
							tick_cnt <= '0;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				TX_DATA: begin
					if (tick16) begin
						if (tick_cnt == uart_pkg::OS_LAST) begin
							tick_cnt <= '0;
							if (bit_idx == 3'd7) begin
								state <= TX_STOP;
								txd <= 1'b1; // Stop bit
							end else begin
								bit_idx <= bit_idx + 1'b1;
								txd <= tx_data[bit_idx + 3'd1];
							end
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				TX_STOP: begin
					// cts comes back only after a full stop bit on the line
					if (tick16) begin
						if (tick_cnt == uart_pkg::OS_LAST)
							state <= TX_IDLE;
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: begin
					state <= TX_IDLE;
					txd <= 1'b1;
				end
			endcase
		end
	end

	a_idle_line_high: assert property (@(posedge clk) disable iff (rst)
		cts |-> txd)
		else $error("txd low while clear to send");

	a_busy_keeps_byte: assert property (@(posedge clk) disable iff (rst)
		(tx_start && !cts) |=> $stable(tx_data))
		else $error("send during a frame changed the latched byte");

endmodule

// File: design/uart_regs.sv
////////////////////////////////////////////////////////////
// Wishbone classic slave and control for the UART
// Holds the send and receive buffers and the rdy and ovr
// flags, decodes commands and answers each access with ack
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_regs (
	input logic clk,
	input logic rst,
	input uart_pkg::wb_req_t bus_req,
	output uart_pkg::wb_rsp_t bus_rsp,
	input logic [7:0] rx_byte,
	input logic rx_valid,
	input logic cts,
	output logic [7:0] tx_byte,
	output logic tx_start
);

	logic ack;
	logic [31:0] rd_dat; // Registered read word
	logic [7:0] tx_buf; // Send buffer
	logic [7:0] rx_buf; // Receive buffer
	logic rdy;
	logic ovr;
	logic req;   // A new access seen this cycle
	logic wr_cmd;
	logic wr_txbuf;
	uart_pkg::wr_word_u wr_word;
	uart_pkg::uart_status_t status;

	// Only the first cycle of a request counts, the held cycle under ack is not a new access
	assign req = bus_req.cyc && bus_req.stb && !ack;
	assign wr_cmd = req && bus_req.we && (bus_req.adr == uart_pkg::ADR_CMD);
	assign wr_txbuf = req && bus_req.we && (bus_req.adr == uart_pkg::ADR_TXBUF);
	assign wr_word = bus_req.dat; // Viewed as a command or as a data byte

	assign status = '{ovr: ovr, rdy: rdy, cts: cts};
	assign bus_rsp = '{dat: rd_dat, ack: ack};
	assign tx_byte = tx_buf; // Transmitter latches it when it accepts tx_start

	// Ack rises in the cycle after the request and drops after one cycle
	always_ff @(posedge clk) begin
		if (rst)
			ack <= 1'b0;
		else
			ack <= req;
	end

	// Read mux, the command register and any unmapped offset read zero
	always_ff @(posedge clk) begin
		if (req) begin
			case (bus_req.adr)
				uart_pkg::ADR_STATUS: rd_dat <= {29'b0, status};
				uart_pkg::ADR_RXBUF: rd_dat <= {24'b0, rx_buf};
				uart_pkg::ADR_TXBUF: rd_dat <= {24'b0, tx_buf};
				default: rd_dat <= 32'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_buf <= 8'h00;
			rx_buf <= 8'h00;
			rdy <= 1'b0;
			ovr <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= wr_cmd && wr_word.cmd.send; // One-cycle pulse in the ack cycle
			if (wr_txbuf)
				tx_buf <= wr_word.data.data;
			if (rx_valid)
				rx_buf <= rx_byte; // Newest byte always wins
			if (wr_cmd && wr_word.cmd.clear) begin
				// Clear beats a same-cycle arrival for ovr, the new byte still sets rdy
				rdy <= rx_valid;
				ovr <= 1'b0;
			end else if (rx_valid) begin
				rdy <= 1'b1;
				ovr <= ovr | rdy; // Previous byte was never collected
			end
		end
	end

	a_single_ack: assert property (@(posedge clk) disable iff (rst)
		ack |=> !ack)
		else $error("ack high in two consecutive cycles");

endmodule

// File: design/uart_top.sv
////////////////////////////////////////////////////////////
// Top level of the memory-mapped UART
// Connects the Wishbone register block to the baud
// generator, the transmitter and the receiver
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_top (
	input logic clk,
	input logic rst,
	input uart_pkg::wb_req_t bus_req,
	output uart_pkg::wb_rsp_t bus_rsp,
	output logic txd,
	input logic rxd
);

	logic tick16; // 16x oversample tick shared by both directions
	logic tx_start;
	logic [7:0] tx_byte;
	logic cts;
	logic [7:0] rx_byte;
	logic rx_valid;

	uart_regs u_regs (
		.clk(clk),
		.rst(rst),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.cts(cts),
		.tx_byte(tx_byte),
		.tx_start(tx_start)
	);

	uart_baud_gen u_baud (
		.clk(clk),
		.rst(rst),
		.tick16(tick16)
	);

	uart_transmitter u_tx (
		.clk(clk),
		.rst(rst),
		.tick16(tick16),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.cts(cts),
		.txd(txd)
	);

	uart_receiver u_rx (
		.clk(clk),
		.rst(rst),
		.tick16(tick16),
		.rxd(rxd),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

endmodule

// File: testbench/tb_clock.sv
////////////////////////////////////////////////////////////
// Clock and reset source for the UART testbench
// 10 ns clock, reset held high for the first three edges
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk <= 1'b0;
		forever #5 clk <= ~clk; // 100 MHz
	end

	// Reset drops on the third rising edge, synchronous to clk
	initial begin
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: testbench/uart_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the memory-mapped UART
// A Wishbone master and a serial line model drive the DUT,
// concurrent assertions compare the results and count errors
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_tb;

	localparam int TIMEOUT_CYCLES = 20000; // About 12 frames plus bus traffic, doubled

	logic clk;
	logic rst;
	uart_pkg::wb_req_t bus_req;
	uart_pkg::wb_rsp_t bus_rsp;
	logic txd;
	logic rxd;

	logic cmp_en; // One-cycle strobe that arms the value check
	logic [31:0] cmp_got;
	logic [31:0] cmp_exp;
	logic line_chk; // Same idea for start and stop bits seen on txd
	logic line_lvl;
	logic line_exp;
	logic [7:0] tx_seen[$]; // Bytes decoded from txd
	logic [15:0] lfsr;
	int mism_cnt = 0;
	int proto_cnt = 0;
	int cycles = 0;

	tb_clock u_clock (.clk(clk), .rst(rst));

	uart_top dut (
		.clk(clk),
		.rst(rst),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.txd(txd),
		.rxd(rxd)
	);

	// Galois LFSR, taps 16,14,13,11, one step per bit taken
	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		logic out;
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			out = lfsr[0];
			lfsr = lfsr >> 1;
			if (out)
				lfsr = lfsr ^ 16'hb400;
			b = {out, b[7:1]};
		end
		return b;
	endfunction

	// Expected status word as the register map defines it
	function automatic logic [31:0] status_word(input logic ovr, input logic rdy, input logic cts);
		uart_pkg::uart_status_t st;
		st.ovr = ovr;
		st.rdy = rdy;
		st.cts = cts;
		return {29'b0, st};
	endfunction

	// Classic single access, the master waits for ack and idles one cycle afterwards
	task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		bus_req <= '{adr: adr, dat: wdat, we: we, stb: 1'b1, cyc: 1'b1};
		@(posedge clk);
		while (!bus_rsp.ack)
			@(posedge clk);
		rdat = bus_rsp.dat; // Valid only while ack is high
		bus_req.stb <= 1'b0;
		bus_req.cyc <= 1'b0;
		bus_req.we <= 1'b0;
		@(posedge clk);
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] wdat);
		logic [31:0] ignored;
		bus_access(1'b1, adr, wdat, ignored);
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
		bus_access(1'b0, adr, 32'h0, rdat);
	endtask

	// Hands a value to the a_value assertion, which samples it on the next edge
	task automatic expect_word(input logic [31:0] got, input logic [31:0] exp);
		cmp_got <= got;
		cmp_exp <= exp;
		cmp_en <= 1'b1;
		@(posedge clk);
		cmp_en <= 1'b0;
	endtask

	task automatic check_line(input logic exp);
		line_lvl <= txd;
		line_exp <= exp;
		line_chk <= 1'b1;
		@(posedge clk);
		line_chk <= 1'b0;
	endtask

	// Serial model, one 8N1 frame on rxd followed by one idle bit
	task automatic drive_frame(input logic [7:0] data, input logic stop);
		rxd <= 1'b0;
		repeat (uart_pkg::BIT_CLKS) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			rxd <= data[i]; // LSB first
			repeat (uart_pkg::BIT_CLKS) @(posedge clk);
		end
		rxd <= stop;
		repeat (uart_pkg::BIT_CLKS) @(posedge clk);
		rxd <= 1'b1;
		repeat (uart_pkg::BIT_CLKS) @(posedge clk);
	endtask

	// Polls status until the transmitter reports clear to send again
	task automatic wait_tx_idle();
		logic [31:0] rd;
		uart_pkg::uart_status_t st;
		bus_read(uart_pkg::ADR_STATUS, rd);
		st = rd[2:0];
		while (!st.cts) begin
			bus_read(uart_pkg::ADR_STATUS, rd);
			st = rd[2:0];
		end
	endtask

	task automatic expect_sent(input logic [7:0] exp);
		logic [7:0] got;
		expect_word(32'(tx_seen.size()), 32'd1); // Exactly one frame went out
		if (tx_seen.size() != 0)
			got = tx_seen.pop_front();
		else
			got = ~exp;
		expect_word({24'h0, got}, {24'h0, exp});
	endtask

	// txd monitor, samples the middle of each bit after the falling edge
	initial begin : txd_monitor
		logic [7:0] b;
		forever begin
			@(posedge clk);
			if (!rst && !txd) begin
				repeat (uart_pkg::BIT_CLKS / 2 - 1) @(posedge clk);
				check_line(1'b0); // Start bit still low at its middle
				repeat (uart_pkg::BIT_CLKS - 1) @(posedge clk);
				for (int i = 0; i < 8; i++) begin
					b = {txd, b[7:1]};
					repeat (uart_pkg::BIT_CLKS) @(posedge clk);
				end
				tx_seen.push_back(b);
				check_line(1'b1); // Stop bit
			end
		end
	end

	a_value: assert property (@(posedge clk) cmp_en |-> cmp_got == cmp_exp)
		else begin
			mism_cnt = mism_cnt + 1;
			$display("mismatch at %0t: read %h, expected %h", $time, $sampled(cmp_got),
				$sampled(cmp_exp));
		end

	a_line: assert property (@(posedge clk) line_chk |-> line_lvl == line_exp)
		else begin
			mism_cnt = mism_cnt + 1;
			$display("mismatch at %0t: framing bit on txd is %b", $time, $sampled(line_lvl));
		end

	a_reset_state: assert property (@(posedge clk) $fell(rst) |-> txd && !bus_rsp.ack)
		else begin
			mism_cnt = mism_cnt + 1;
			$display("mismatch at %0t: txd or ack wrong after reset", $time);
		end

	// Bus protocol, one ack per request and only after a request
	a_ack_once: assert property (@(posedge clk) disable iff (rst)
		bus_rsp.ack |=> !bus_rsp.ack)
		else begin
			proto_cnt = proto_cnt + 1;
			$display("At %0t ack stayed high for more than one cycle", $time);
		end

	a_ack_follows: assert property (@(posedge clk) disable iff (rst)
		$rose(bus_req.stb) |=> bus_rsp.ack)
		else begin
			proto_cnt = proto_cnt + 1;
			$display("At %0t an access was not acknowledged in the next cycle", $time);
		end

	a_no_stray_ack: assert property (@(posedge clk) disable iff (rst)
		bus_rsp.ack |-> $past(bus_req.stb))
		else begin
			proto_cnt = proto_cnt + 1;
			$display("At %0t ack arrived without a request", $time);
		end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles because the test did not finish", cycles);
			$display("Errors: %0d mismatches, %0d protocol", mism_cnt, proto_cnt);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin : stimulus
		logic [31:0] rd;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		bus_req <= '0;
		rxd <= 1'b1; // Idle line
		cmp_en <= 1'b0;
		line_chk <= 1'b0;
		lfsr = 16'd14;
		while (rst)
			@(posedge clk);

		// Reset values and plain register access
		bus_read(uart_pkg::ADR_STATUS, rd);
		expect_word(rd, status_word(1'b0, 1'b0, 1'b1));
		b0 = rand_byte();
		bus_write(uart_pkg::ADR_TXBUF, {24'ha5c3e1, b0}); // Upper bits must be dropped
		bus_read(uart_pkg::ADR_TXBUF, rd);
		expect_word(rd, {24'h0, b0});
		bus_read(uart_pkg::ADR_CMD, rd);
		expect_word(rd, 32'h0);
		bus_write(32'h0000_0010, 32'hffff_ffff);
		bus_read(32'h0000_0010, rd);
		expect_word(rd, 32'h0);

		// Send, then a second send mid-frame that must be ignored
		bus_write(uart_pkg::ADR_CMD, 32'd1);
		bus_read(uart_pkg::ADR_STATUS, rd);
		expect_word(rd, status_word(1'b0, 1'b0, 1'b0));
		bus_write(uart_pkg::ADR_TXBUF, {24'h0, ~b0});
		bus_write(uart_pkg::ADR_CMD, 32'd1);
		wait_tx_idle();
		expect_sent(b0);
		repeat (11 * uart_pkg::BIT_CLKS) @(posedge clk); // Room for a stray frame to show up
		expect_word(32'(tx_seen.size()), 32'd0);

		// Receive, read back and clear
		b1 = rand_byte();
		drive_frame(b1, 1'b1);
		bus_read(uart_pkg::ADR_STATUS, rd);
		expect_word(rd, status_word(1'b0, 1'b1, 1'b1));
		bus_read(uart_pkg::ADR_RXBUF, rd);
		expect_word(rd, {24'h0, b1});
		bus_write(uart_pkg::ADR_CMD, 32'd2);
		bus_read(uart_pkg::ADR_STATUS, rd);
		expect_word(rd, status_word(1'b0, 1'b0, 1'b1));

		// Send and clear in one command
		b2 = rand_byte();
		drive_frame(b2, 1'b1);
		b0 = rand_byte();
		bus_write(uart_pkg::ADR_TXBUF, {24'h0, b0});
		bus_write(uart_pkg::ADR_CMD, 32'd3);
		bus_read(uart_pkg::ADR_STATUS, rd);
		expect_word(rd, status_word(1'b0, 1'b0, 1'b0));
		wait_tx_idle();
		expect_sent(b0);

		// Overrun, then a frame with a low stop bit
		b1 = rand_byte();
		drive_frame(b1, 1'b1);
		b2 = rand_byte();
		drive_frame(b2, 1'b1);
		bus_read(uart_pkg::ADR_STATUS, rd);
		expect_word(rd, status_word(1'b1, 1'b1, 1'b1));
		bus_read(uart_pkg::ADR_RXBUF, rd);
		expect_word(rd, {24'h0, b2}); // Newest byte wins
		bus_write(uart_pkg::ADR_CMD, 32'd2);
		bus_read(uart_pkg::ADR_STATUS, rd);
		expect_word(rd, status_word(1'b0, 1'b0, 1'b1));
		drive_frame(~b2, 1'b0);
		bus_read(uart_pkg::ADR_STATUS, rd);
		expect_word(rd, status_word(1'b0, 1'b0, 1'b1));
		bus_read(uart_pkg::ADR_RXBUF, rd);
		expect_word(rd, {24'h0, b2});

		repeat (4) @(posedge clk); // Let the last assertions sample
		$display("Errors: %0d mismatches, %0d protocol", mism_cnt, proto_cnt);
		if (mism_cnt == 0 && proto_cnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: all.f
design/uart_pkg.sv
design/uart_baud_gen.sv
design/uart_receiver.sv
design/uart_transmitter.sv
design/uart_regs.sv
design/uart_top.sv
testbench/tb_clock.sv
testbench/uart_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the UART testbench with Verilator and runs it
# Passes only when the pass message shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module uart_tb -f all.f -o uart_sim &&
./obj_dir/uart_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
